// File: logic/feeder_pkg.sv
// Operand widths, index types, memory word union, host/memory/pair structs, sequencer states
package feeder_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int DATA_WIDTH  = 8;
  localparam int IF_WIDTH    = 4;
  localparam int KERNEL_SIZE = 3;
  localparam int NUM_POS     = IF_WIDTH - KERNEL_SIZE + 1;
  localparam int WORD_WIDTH  = 32;
  localparam int ADDR_WIDTH  = 5;
  localparam int ROW_WIDTH   = 4;

  // Bits left over above flags and weights
  localparam int PAD_WIDTH = WORD_WIDTH - KERNEL_SIZE - KERNEL_SIZE * DATA_WIDTH;

  typedef logic [1:0] act_index_t;
  typedef logic [1:0] wei_index_t;

  // ==============================
  // Memory word views
  // ==============================
  // Weight 0 sits in the low byte
  typedef struct packed {
    logic [PAD_WIDTH-1:0]                   pad;
    logic [KERNEL_SIZE-1:0]                 nz_flags;
    logic [KERNEL_SIZE-1:0][DATA_WIDTH-1:0] wei;
  } wei_view_t;

  typedef union packed {
    logic [IF_WIDTH-1:0][DATA_WIDTH-1:0] act_view;
    wei_view_t                           wei_view;
  } operand_word_u;

  // ==============================
  // Request and output bundles
  // ==============================
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WORD_WIDTH-1:0] data;
  } host_wr_t;

  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WORD_WIDTH-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] act;
    logic [DATA_WIDTH-1:0] wei;
    act_index_t            act_index;
    wei_index_t            wei_col_index;
    logic [ROW_WIDTH-1:0]  row_index;
  } pair_t;

  typedef enum logic [1:0] {
    PREP,
    TRAN,
    COMP,
    WAIT
  } seq_state_e;

endpackage

// File: logic/mem_arbiter.sv
// Fixed-priority arbiter for host writes and the two operand fetchers
`timescale 1ns/1ps

module mem_arbiter
  import feeder_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  host_wr_t              host_wr,
  input  logic                  wei_req,
  input  logic [ADDR_WIDTH-1:0] wei_addr,
  input  logic                  act_req,
  input  logic [ADDR_WIDTH-1:0] act_addr,
  output logic                  wei_grant,
  output logic                  act_grant,
  output mem_req_t              mem_req
);

  // Set for one cycle after a grant
  logic wei_hold;
  logic act_hold;

  // ==============================
  // Priority: host, weight, activation
  // ==============================
  assign wei_grant = wei_req && !wei_hold && !host_wr.valid;
  assign act_grant = act_req && !act_hold && !host_wr.valid && !wei_grant;

  always_comb begin
    mem_req = '0;
    if (host_wr.valid) begin
      mem_req.en   = 1'b1;
      mem_req.we   = 1'b1;
      mem_req.addr = host_wr.addr;
      mem_req.data = host_wr.data;
    end else if (wei_grant) begin
      mem_req.en   = 1'b1;
      mem_req.addr = wei_addr;
    end else if (act_grant) begin
      mem_req.en   = 1'b1;
      mem_req.addr = act_addr;
    end
  end

  // A requester just served is masked so a late request is not read twice
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      wei_hold <= 1'b0;
      act_hold <= 1'b0;
    end else begin
      wei_hold <= wei_grant;
      act_hold <= act_grant;
    end
  end

endmodule

// File: logic/operand_fetch.sv
// Operand fetcher that reads the word at base plus row and holds it
`timescale 1ns/1ps

module operand_fetch
  import feeder_pkg::*;
#(
  parameter int BASE_ADDR = 0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fetch,
  input  logic [ROW_WIDTH-1:0]  row_index,
  input  logic                  mem_grant,
  input  operand_word_u         rd_data,
  output logic                  mem_req,
  output logic [ADDR_WIDTH-1:0] mem_addr,
  output operand_word_u         word,
  output logic                  word_valid
);

  typedef enum logic [1:0] {
    F_IDLE,
    F_REQ,
    F_CAP
  } fetch_state_e;

  fetch_state_e          fstate;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [ADDR_WIDTH-1:0] row_addr;

  assign row_addr = ADDR_WIDTH'(BASE_ADDR) + ADDR_WIDTH'(row_index);

  // Request goes out in the fetch cycle itself
  assign mem_req  = fetch || (fstate == F_REQ);
  assign mem_addr = fetch ? row_addr : addr_q;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      fstate     <= F_IDLE;
      word_valid <= 1'b0;
    end else if (fetch) begin
      word_valid <= 1'b0;
      fstate     <= mem_grant ? F_CAP : F_REQ;
    end else begin
      case (fstate)
        F_REQ: begin
          if (mem_grant) begin
            fstate <= F_CAP;
          end
        end
        F_CAP: begin
          word_valid <= 1'b1;
          fstate     <= F_IDLE;
        end
        default: fstate <= F_IDLE;
      endcase
    end
  end

  // Read data lands the cycle after the grant
  always_ff @(posedge clk) begin
    if (fetch) begin
      addr_q <= row_addr;
    end
    if (fstate == F_CAP) begin
      word <= rd_data;
    end
  end

endmodule

// File: logic/operand_mem.sv
// Single-port operand memory with one-cycle registered read
`timescale 1ns/1ps

module operand_mem
  import feeder_pkg::*;
#(
  parameter int MEM_DEPTH = 32
) (
  input  logic          clk,
  input  mem_req_t      req,
  output operand_word_u rd_data
);

  logic [WORD_WIDTH-1:0] mem [MEM_DEPTH];

  // Read returns the old contents on a write cycle
  always_ff @(posedge clk) begin
    if (req.en) begin
      if (req.we) begin
        mem[req.addr] <= req.data;
      end
      rd_data <= mem[req.addr];
    end
  end

endmodule

// File: logic/pair_sequencer.sv
// Row sequencer that skips zero weights and emits activation/weight pairs
`timescale 1ns/1ps

module pair_sequencer
  import feeder_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [ROW_WIDTH-1:0] num_rows,
  input  operand_word_u        act_word,
  input  operand_word_u        wei_word,
  input  logic                 words_valid,
  input  logic                 pair_ready,
  output logic                 fetch,
  output logic [ROW_WIDTH-1:0] row_index,
  output pair_t                pair,
  output logic                 pair_valid,
  output logic                 row_done,
  output logic [1:0]           row_val_num,
  output logic                 zero_flag,
  output logic                 busy
);

  typedef struct packed {
    logic       found;
    wei_index_t col;
  } col_pick_t;

  seq_state_e             state;
  seq_state_e             next_state;
  logic [ROW_WIDTH-1:0]   num_rows_q;
  act_index_t             pos_q;
  wei_index_t             col_q;
  act_index_t             act_sel;
  logic                   sel_done;
  logic [KERNEL_SIZE-1:0] flags;
  logic                   start_ok;
  logic                   words_ok;
  logic                   last_row;
  logic                   in_comp;
  logic                   xfer;
  logic                   load;
  logic                   zero_row_end;
  logic                   row_end;
  col_pick_t              first_pick;
  col_pick_t              next_pick;

  // Lowest set flag at or above column from
  function automatic col_pick_t find_col(input logic [KERNEL_SIZE-1:0] f,
                                         input wei_index_t from);
    col_pick_t pick;
    pick = '0;
    for (int c = KERNEL_SIZE - 1; c >= 0; c--) begin
      if (f[c] && (c >= int'(from))) begin
        pick.found = 1'b1;
        pick.col   = wei_index_t'(c);
      end
    end
    return pick;
  endfunction

  assign flags      = wei_word.wei_view.nz_flags;
  assign first_pick = find_col(flags, '0);
  assign next_pick  = find_col(flags, col_q + 1'b1);
  assign act_sel    = pos_q + col_q;

  // ==============================
  // Handshake and row control
  // ==============================
  assign start_ok = (state == PREP) && start && (num_rows != '0);
  // Words from the previous row are still flagged valid in the fetch cycle
  assign words_ok     = (state == TRAN) && !fetch && words_valid;
  assign last_row     = (row_index == num_rows_q - 1'b1);
  assign in_comp      = (state == COMP) || (state == WAIT);
  assign xfer         = pair_valid && pair_ready;
  assign load         = in_comp && !sel_done && (!pair_valid || pair_ready);
  assign zero_row_end = words_ok && (flags == '0);
  assign row_end      = zero_row_end || (in_comp && sel_done && xfer);
  assign busy         = (state != PREP) || row_done;

  always_comb begin
    next_state = state;
    case (state)
      PREP: begin
        if (start_ok) begin
          next_state = TRAN;
        end
      end
      TRAN: begin
        if (zero_row_end && last_row) begin
          next_state = PREP;
        end else if (words_ok && !zero_row_end) begin
          next_state = COMP;
        end
      end
      COMP, WAIT: begin
        if (row_end) begin
          next_state = last_row ? PREP : TRAN;
        end else if (pair_valid && !pair_ready) begin
          next_state = WAIT;
        end else begin
          next_state = COMP;
        end
      end
      default: next_state = PREP;
    endcase
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state       <= PREP;
      num_rows_q  <= '0;
      row_index   <= '0;
      fetch       <= 1'b0;
      row_done    <= 1'b0;
      row_val_num <= '0;
      zero_flag   <= 1'b0;
      pos_q       <= '0;
      col_q       <= '0;
      sel_done    <= 1'b0;
      pair_valid  <= 1'b0;
    end else begin
      state    <= next_state;
      fetch    <= start_ok || (row_end && !last_row);
      row_done <= row_end;
      if (start_ok) begin
        num_rows_q <= num_rows;
        row_index  <= '0;
      end else if (row_end) begin
        row_index <= row_index + 1'b1;
      end
      // Cursor walks positions, then set columns in ascending order
      if (words_ok) begin
        row_val_num <= 2'($countones(flags));
        zero_flag   <= (flags == '0);
        pos_q       <= '0;
        col_q       <= first_pick.col;
        sel_done    <= !first_pick.found;
      end else if (load) begin
        if (next_pick.found) begin
          col_q <= next_pick.col;
        end else if (pos_q == act_index_t'(NUM_POS - 1)) begin
          sel_done <= 1'b1;
        end else begin
          pos_q <= pos_q + 1'b1;
          col_q <= first_pick.col;
        end
      end
      if (load) begin
        pair_valid <= 1'b1;
      end else if (xfer) begin
        pair_valid <= 1'b0;
      end
    end
  end

  // Output register, held while the consumer stalls
  always_ff @(posedge clk) begin
    if (load) begin
      pair.act           <= act_word.act_view[act_sel];
      pair.wei           <= wei_word.wei_view.wei[col_q];
      pair.act_index     <= act_sel;
      pair.wei_col_index <= col_q;
      pair.row_index     <= row_index;
    end
  end

endmodule

// File: logic/sparse_feeder_top.sv
// Top level tying operand memory, arbiter, both fetchers and the pair sequencer
`timescale 1ns/1ps

module sparse_feeder_top
  import feeder_pkg::*;
#(
  parameter int MEM_DEPTH = 32,
  parameter int ACT_BASE  = 0,
  parameter int WEI_BASE  = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  host_wr_t             host_wr,
  input  logic                 start,
  input  logic [ROW_WIDTH-1:0] num_rows,
  input  logic                 pair_ready,
  output pair_t                pair,
  output logic                 pair_valid,
  output logic                 row_done,
  output logic [1:0]           row_val_num,
  output logic                 zero_flag,
  output logic                 busy
);

  mem_req_t              mem_req;
  operand_word_u         rd_data;
  logic                  fetch;
  logic [ROW_WIDTH-1:0]  row_index;
  logic                  wei_req;
  logic                  act_req;
  logic [ADDR_WIDTH-1:0] wei_addr;
  logic [ADDR_WIDTH-1:0] act_addr;
  logic                  wei_grant;
  logic                  act_grant;
  operand_word_u         wei_word;
  operand_word_u         act_word;
  logic                  wei_valid;
  logic                  act_valid;

  // ==============================
  // Shared operand memory
  // ==============================
  operand_mem #(.MEM_DEPTH(MEM_DEPTH)) u_mem (
    .clk     (clk),
    .req     (mem_req),
    .rd_data (rd_data)
  );

  mem_arbiter u_arb (
    .clk       (clk),
    .reset     (reset),
    .host_wr   (host_wr),
    .wei_req   (wei_req),
    .wei_addr  (wei_addr),
    .act_req   (act_req),
    .act_addr  (act_addr),
    .wei_grant (wei_grant),
    .act_grant (act_grant),
    .mem_req   (mem_req)
  );

  // ==============================
  // Fetchers and sequencer
  // ==============================
  operand_fetch #(.BASE_ADDR(WEI_BASE)) fetch_wei (
    .clk        (clk),
    .reset      (reset),
    .fetch      (fetch),
    .row_index  (row_index),
    .mem_grant  (wei_grant),
    .rd_data    (rd_data),
    .mem_req    (wei_req),
    .mem_addr   (wei_addr),
    .word       (wei_word),
    .word_valid (wei_valid)
  );

  operand_fetch #(.BASE_ADDR(ACT_BASE)) fetch_act (
    .clk        (clk),
    .reset      (reset),
    .fetch      (fetch),
    .row_index  (row_index),
    .mem_grant  (act_grant),
    .rd_data    (rd_data),
    .mem_req    (act_req),
    .mem_addr   (act_addr),
    .word       (act_word),
    .word_valid (act_valid)
  );

  pair_sequencer u_seq (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .num_rows    (num_rows),
    .act_word    (act_word),
    .wei_word    (wei_word),
    .words_valid (wei_valid && act_valid),
    .pair_ready  (pair_ready),
    .fetch       (fetch),
    .row_index   (row_index),
    .pair        (pair),
    .pair_valid  (pair_valid),
    .row_done    (row_done),
    .row_val_num (row_val_num),
    .zero_flag   (zero_flag),
    .busy        (busy)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module tb_sparse_feeder \
  -Mdir obj_dir -o sim_feeder

./obj_dir/sim_feeder > sim.log
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
exit 1

// File: tests/tb_feeder_tasks.svh
// Testbench helpers: host writes, run control, reference pair model and typed compare tasks
`ifndef TB_FEEDER_TASKS_SVH
`define TB_FEEDER_TASKS_SVH

// ==============================
// Stimulus
// ==============================
task automatic wait_drive_slot();
  @(posedge clk);
  #10;
endtask

task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [WORD_WIDTH-1:0] data);
  wait_drive_slot();
  host_wr.valid = 1'b1;
  host_wr.addr  = addr;
  host_wr.data  = data;
endtask

task automatic host_idle();
  wait_drive_slot();
  host_wr.valid = 1'b0;
endtask

// Writes to addresses no row uses, while noise_on is set
task automatic host_noise();
  logic [ADDR_WIDTH-1:0] addr;
  while (noise_on) begin
    wait_drive_slot();
    addr          = ADDR_WIDTH'(8 + ($urandom % 8) + 16 * ($urandom % 2));
    host_wr.valid = (($urandom % 4) != 0);
    host_wr.addr  = addr;
    host_wr.data  = $urandom;
  end
  host_wr.valid = 1'b0;
endtask

// ==============================
// Reference model
// ==============================
// Per position, then each set flag in ascending column order
task automatic expect_row(input logic [ROW_WIDTH-1:0] row, input operand_word_u act,
                          input operand_word_u wei);
  pair_t       e;
  row_status_t st;
  act_index_t  ai;
  wei_index_t  wc;
  int          count;
  count = 0;
  for (int p = 0; p < NUM_POS; p++) begin
    for (int c = 0; c < KERNEL_SIZE; c++) begin
      wc = wei_index_t'(c);
      ai = act_index_t'(p + c);
      if (wei.wei_view.nz_flags[wc]) begin
        e.act           = act.act_view[ai];
        e.wei           = wei.wei_view.wei[wc];
        e.act_index     = ai;
        e.wei_col_index = wc;
        e.row_index     = row;
        exp_pairs.push_back(e);
        if (p == 0) begin
          count++;
        end
      end
    end
  end
  st.val_num = 2'(count);
  st.zero    = (count == 0);
  exp_status.push_back(st);
endtask

// Random activations and weights; unflagged weights are zero
task automatic load_row(input logic [ROW_WIDTH-1:0] row, input logic [KERNEL_SIZE-1:0] flags);
  operand_word_u act;
  operand_word_u wei;
  wei_index_t    wc;
  act = $urandom;
  wei = $urandom;
  wei.wei_view.pad      = '0;
  wei.wei_view.nz_flags = flags;
  for (int c = 0; c < KERNEL_SIZE; c++) begin
    wc = wei_index_t'(c);
    if (!flags[wc]) begin
      wei.wei_view.wei[wc] = '0;
    end
  end
  write_word(ADDR_WIDTH'(ACT_BASE) + ADDR_WIDTH'(row), act);
  write_word(ADDR_WIDTH'(WEI_BASE) + ADDR_WIDTH'(row), wei);
  expect_row(row, act, wei);
endtask

// ==============================
// Compare tasks
// ==============================
task automatic check_pair(input pair_t expected, input pair_t actual);
  if (actual !== expected) begin
    pair_errors++;
    $display("[FAIL] %s pair: expected %h actual %h", cur_test, expected, actual);
  end
endtask

task automatic check_status(input logic [1:0] exp_num, input logic exp_zero,
                            input logic [1:0] act_num, input logic act_zero);
  if ((act_num !== exp_num) || (act_zero !== exp_zero)) begin
    status_errors++;
    $display("[FAIL] %s status: expected num=%0d zero=%b actual num=%0d zero=%b",
             cur_test, exp_num, exp_zero, act_num, act_zero);
  end
endtask

task automatic check_flag(input string what, input logic expected, input logic actual);
  if (actual !== expected) begin
    other_errors++;
    $display("[FAIL] %s %s: expected %b actual %b", cur_test, what, expected, actual);
  end
endtask

`endif

// File: tests/tb_sparse_feeder.sv
// Sparse feeder testbench with clock, reset, DUT, pair monitor, directed tests, timeout and result
`timescale 1ns/1ps

module tb_sparse_feeder
  import feeder_pkg::*;
();

  localparam int MEM_DEPTH      = 32;
  localparam int ACT_BASE       = 0;
  localparam int WEI_BASE       = 16;
  localparam int TOTAL_ROWS     = 9;
  localparam int TIMEOUT_CYCLES = 200 * TOTAL_ROWS + 100;

  typedef struct packed {
    logic [1:0] val_num;
    logic       zero;
  } row_status_t;

  logic                 clk;
  logic                 reset;
  host_wr_t             host_wr;
  logic                 start;
  logic [ROW_WIDTH-1:0] num_rows;
  logic                 pair_ready;
  pair_t                pair;
  logic                 pair_valid;
  logic                 row_done;
  logic [1:0]           row_val_num;
  logic                 zero_flag;
  logic                 busy;

  pair_t       exp_pairs[$];
  row_status_t exp_status[$];
  row_status_t st_next;
  pair_t       held_pair;
  logic        was_stalled = 1'b0;
  logic        random_ready = 1'b0;
  logic        noise_on = 1'b0;
  string       cur_test = "reset_state";
  int          pair_errors = 0;
  int          status_errors = 0;
  int          other_errors = 0;
  int          cycles = 0;
  int          seed_result;

  `include "tb_feeder_tasks.svh"

  sparse_feeder_top #(
    .MEM_DEPTH (MEM_DEPTH),
    .ACT_BASE  (ACT_BASE),
    .WEI_BASE  (WEI_BASE)
  ) uut (
    .clk         (clk),
    .reset       (reset),
    .host_wr     (host_wr),
    .start       (start),
    .num_rows    (num_rows),
    .pair_ready  (pair_ready),
    .pair        (pair),
    .pair_valid  (pair_valid),
    .row_done    (row_done),
    .row_val_num (row_val_num),
    .zero_flag   (zero_flag),
    .busy        (busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Consumer ready goes random when back-pressure is on
  initial begin
    pair_ready = 1'b1;
    forever begin
      wait_drive_slot();
      pair_ready = random_ready ? (($urandom % 3) != 0) : 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ==============================
  // Output monitor at mid-cycle
  // ==============================
  always @(negedge clk) begin
    if (reset) begin
      if (was_stalled) begin
        check_flag("pair_valid held", 1'b1, pair_valid);
        check_pair(held_pair, pair);
      end
      if (pair_valid && pair_ready) begin
        if (exp_pairs.size() == 0) begin
          other_errors++;
          $display("%s: a pair was transferred when none was expected", cur_test);
        end else begin
          check_pair(exp_pairs.pop_front(), pair);
        end
      end
      was_stalled = pair_valid && !pair_ready;
      held_pair   = pair;
      if (row_done) begin
        if (exp_status.size() == 0) begin
          other_errors++;
          $display("%s: row_done pulsed with no row outstanding", cur_test);
        end else begin
          st_next = exp_status.pop_front();
          check_status(st_next.val_num, st_next.zero, row_val_num, zero_flag);
        end
      end
    end
  end

  // Start a run and wait for busy to fall
  task automatic run_rows(input logic [ROW_WIDTH-1:0] n);
    logic done_before;
    done_before = 1'b0;
    wait_drive_slot();
    num_rows = n;
    start    = 1'b1;
    wait_drive_slot();
    start = 1'b0;
    @(negedge clk);
    check_flag("busy after start", 1'b1, busy);
    while (busy) begin
      done_before = row_done;
      @(negedge clk);
    end
    // Busy drops the cycle after the last row_done
    check_flag("row_done before busy falls", 1'b1, done_before);
    if (exp_pairs.size() != 0) begin
      other_errors++;
      $display("%s: %0d expected pairs never came out", cur_test, exp_pairs.size());
    end
    if (exp_status.size() != 0) begin
      other_errors++;
      $display("%s: %0d rows ended without row_done", cur_test, exp_status.size());
    end
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_reset_state();
    cur_test = "reset_state";
    @(negedge clk);
    check_flag("pair_valid", 1'b0, pair_valid);
    check_flag("row_done", 1'b0, row_done);
    check_flag("busy", 1'b0, busy);
  endtask

  task automatic test_single_row(input string name, input logic [KERNEL_SIZE-1:0] flags);
    cur_test = name;
    load_row(4'd0, flags);
    host_idle();
    run_rows(4'd1);
  endtask

  task automatic test_backpressure();
    cur_test = "backpressure";
    for (int r = 0; r < 3; r++) begin
      load_row(ROW_WIDTH'(r), KERNEL_SIZE'($urandom));
    end
    host_idle();
    random_ready = 1'b1;
    run_rows(4'd3);
    random_ready = 1'b0;
  endtask

  task automatic test_host_traffic();
    cur_test = "host_traffic";
    for (int r = 0; r < 3; r++) begin
      load_row(ROW_WIDTH'(r), KERNEL_SIZE'($urandom));
    end
    host_idle();
    noise_on = 1'b1;
    fork
      begin
        run_rows(4'd3);
        noise_on = 1'b0;
      end
      host_noise();
    join
  endtask

  initial begin
    seed_result = $urandom(32'hb232f31d);
    reset       = 1'b0;
    host_wr     = '0;
    start       = 1'b0;
    num_rows    = '0;
    repeat (4) @(posedge clk);
    #10;
    reset = 1'b1;
    test_reset_state();
    test_single_row("dense_row", 3'b111);
    test_single_row("sparse_row", 3'b101);
    test_single_row("zero_row", 3'b000);
    test_backpressure();
    test_host_traffic();
    wait_drive_slot();
    $display("Errors: pair=%0d status=%0d other=%0d", pair_errors, status_errors, other_errors);
    if ((pair_errors + status_errors + other_errors) == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tests
logic/feeder_pkg.sv
logic/operand_mem.sv
logic/mem_arbiter.sv
logic/operand_fetch.sv
logic/pair_sequencer.sv
logic/sparse_feeder_top.sv
tests/tb_sparse_feeder.sv
